// File: Makefile
SIM := obj_dir/Vtb_rv_core

$(SIM): build.f rv_pkg.sv instr_ctl.sv imm_gen.sv reg_file.sv exec_unit.sv \
		fetch_unit.sv lsu.sv rv_core.sv tb_ref_model.sv tb_rv_core.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_rv_core -f build.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: build.f
rv_pkg.sv
instr_ctl.sv
imm_gen.sv
reg_file.sv
exec_unit.sv
fetch_unit.sv
lsu.sv
rv_core.sv
tb_ref_model.sv
tb_rv_core.sv

// File: exec_unit.sv
`default_nettype none

module exec_unit (
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::word_t    imm,
    input  logic             a_sel,
    input  logic             b_sel,
    input  rv_pkg::alu_sel_t alu_sel,
    input  logic             br_un,
    output rv_pkg::word_t    alu_result,
    output logic             br_eq,
    output logic             br_lt
);

    rv_pkg::word_t                      op_a;
    rv_pkg::word_t                      op_b;
    logic [$clog2(rv_pkg::XLEN)-1:0]    shamt;

    assign op_a  = a_sel ? pc : rs1_data;
    assign op_b  = b_sel ? imm : rs2_data;
    assign shamt = op_b[$clog2(rv_pkg::XLEN)-1:0];

    always_comb begin
        case (alu_sel)
            rv_pkg::ALU_ADD:   alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:   alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:   alu_result = op_a << shamt;
            rv_pkg::ALU_SLT:   alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_SLTU:  alu_result = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::ALU_XOR:   alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:   alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:   alu_result = rv_pkg::word_t'($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:    alu_result = op_a | op_b;
            rv_pkg::ALU_AND:   alu_result = op_a & op_b;
            rv_pkg::ALU_PASSB: alu_result = op_b;
            default:           alu_result = op_a + op_b;
        endcase
    end

    // Branch comparator always looks at the two source registers
    assign br_eq = (rs1_data == rs2_data);
    assign br_lt = br_un ? (rs1_data < rs2_data) : ($signed(rs1_data) < $signed(rs2_data));

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pc_sel,
    input  rv_pkg::word_t target,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t pc_plus4
);

    rv_pkg::word_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    // Jump and branch targets lose their low two bits
    assign next_pc = pc_sel ? {target[rv_pkg::XLEN-1:2], 2'b00} : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= rv_pkg::RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch_unit: pc not word aligned");

endmodule

`default_nettype wire

// File: imm_gen.sv
`default_nettype none

module imm_gen (
    input  rv_pkg::word_t    instruction,
    input  rv_pkg::imm_sel_t imm_sel,
    output rv_pkg::word_t    imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (imm_sel)
            rv_pkg::IMM_I: begin
                imm = {{(rv_pkg::XLEN-12){sign}}, instruction[31:20]};
            end
            rv_pkg::IMM_S: begin
                imm = {{(rv_pkg::XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
            end
            rv_pkg::IMM_B: begin
                imm = {{(rv_pkg::XLEN-12){sign}}, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            rv_pkg::IMM_U: begin
                imm = {instruction[31:12], 12'b0};
            end
            rv_pkg::IMM_J: begin
                imm = {{(rv_pkg::XLEN-20){sign}}, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: instr_ctl.sv
`default_nettype none

module instr_ctl (
    input  rv_pkg::word_t     instruction,
    input  logic              br_eq,
    input  logic              br_lt,
    output logic              a_sel,
    output logic              b_sel,
    output rv_pkg::alu_sel_t  alu_sel,
    output rv_pkg::imm_sel_t  imm_sel,
    output logic              br_un,
    output logic              pc_sel,
    output logic              reg_wen,
    output logic              mem_wr,
    output logic              mem_rd,
    output rv_pkg::mem_size_t mem_size,
    output logic              load_unsigned,
    output rv_pkg::wb_sel_t   wb_sel
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             funct7_5;
    rv_pkg::alu_sel_t alu_op;

    assign opcode   = instruction[6:0];
    assign funct3   = instruction[14:12];
    assign funct7_5 = instruction[30];

    // Shared by OP and OP-IMM, SUB only exists in OP
    always_comb begin
        case (funct3)
            rv_pkg::F3_ADD: begin
                if (funct7_5 && opcode == rv_pkg::OPC_OP) begin
                    alu_op = rv_pkg::ALU_SUB;
                end else begin
                    alu_op = rv_pkg::ALU_ADD;
                end
            end
            rv_pkg::F3_SLL:  alu_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:  alu_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU: alu_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:  alu_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:   alu_op = funct7_5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:   alu_op = rv_pkg::ALU_OR;
            rv_pkg::F3_AND:  alu_op = rv_pkg::ALU_AND;
            default:         alu_op = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        // Defaults form a no-operation
        a_sel         = 1'b0;
        b_sel         = 1'b1;
        alu_sel       = rv_pkg::ALU_ADD;
        imm_sel       = rv_pkg::IMM_I;
        br_un         = 1'b0;
        pc_sel        = 1'b0;
        reg_wen       = 1'b0;
        mem_wr        = 1'b0;
        mem_rd        = 1'b0;
        mem_size      = rv_pkg::SIZE_W;
        load_unsigned = 1'b0;
        wb_sel        = rv_pkg::WB_ALU;

        case (opcode)
            rv_pkg::OPC_LUI: begin
                alu_sel = rv_pkg::ALU_PASSB;
                imm_sel = rv_pkg::IMM_U;
                reg_wen = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                a_sel   = 1'b1;
                imm_sel = rv_pkg::IMM_U;
                reg_wen = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                a_sel   = 1'b1;
                imm_sel = rv_pkg::IMM_J;
                pc_sel  = 1'b1;
                reg_wen = 1'b1;
                wb_sel  = rv_pkg::WB_PC4;
            end
            rv_pkg::OPC_JALR: begin
                pc_sel  = 1'b1;
                reg_wen = 1'b1;
                wb_sel  = rv_pkg::WB_PC4;
            end
            rv_pkg::OPC_BRANCH: begin
                // Target is PC + B immediate
                a_sel   = 1'b1;
                imm_sel = rv_pkg::IMM_B;
                br_un   = funct3[1];
                case (funct3)
                    rv_pkg::F3_BEQ:                  pc_sel = br_eq;
                    rv_pkg::F3_BNE:                  pc_sel = !br_eq;
                    rv_pkg::F3_BLT, rv_pkg::F3_BLTU: pc_sel = br_lt;
                    rv_pkg::F3_BGE, rv_pkg::F3_BGEU: pc_sel = !br_lt;
                    default:                         pc_sel = 1'b0;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                wb_sel        = rv_pkg::WB_MEM;
                load_unsigned = funct3[2];
                case (funct3)
                    rv_pkg::F3_LB, rv_pkg::F3_LBU: begin
                        mem_size = rv_pkg::SIZE_B;
                        mem_rd   = 1'b1;
                    end
                    rv_pkg::F3_LH, rv_pkg::F3_LHU: begin
                        mem_size = rv_pkg::SIZE_H;
                        mem_rd   = 1'b1;
                    end
                    rv_pkg::F3_LW: mem_rd = 1'b1;
                    default:       mem_rd = 1'b0;
                endcase
                reg_wen = mem_rd;
            end
            rv_pkg::OPC_STORE: begin
                imm_sel = rv_pkg::IMM_S;
                case (funct3)
                    rv_pkg::F3_SB: begin
                        mem_size = rv_pkg::SIZE_B;
                        mem_wr   = 1'b1;
                    end
                    rv_pkg::F3_SH: begin
                        mem_size = rv_pkg::SIZE_H;
                        mem_wr   = 1'b1;
                    end
                    rv_pkg::F3_SW: mem_wr = 1'b1;
                    default:       mem_wr = 1'b0;
                endcase
            end
            rv_pkg::OPC_OPIMM: begin
                alu_sel = alu_op;
                reg_wen = 1'b1;
            end
            rv_pkg::OPC_OP: begin
                b_sel   = 1'b0;
                alu_sel = alu_op;
                reg_wen = 1'b1;
            end
            // Unknown opcode falls through to the PC+4 no-operation
            default: pc_sel = 1'b0;
        endcase
    end

    always_comb begin
        assert (!(mem_wr && reg_wen))
            else $error("instr_ctl: store and register write decoded together");
    end

endmodule

`default_nettype wire

// File: lsu.sv
`default_nettype none

module lsu (
    input  logic              rst_n,
    input  rv_pkg::word_t     addr,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     alu_result,
    input  rv_pkg::word_t     pc_plus4,
    input  rv_pkg::word_t     mem_rdata,
    input  logic              mem_wr,
    input  logic              mem_rd,
    input  rv_pkg::mem_size_t mem_size,
    input  logic              load_unsigned,
    input  rv_pkg::wb_sel_t   wb_sel,
    output rv_pkg::word_t     mem_wdata,
    output logic [3:0]        mem_we,
    output rv_pkg::word_t     rd_data
);

    logic [1:0]    ofs;
    logic [3:0]    strobe;
    logic [7:0]    ld_byte;
    logic [15:0]   ld_half;
    rv_pkg::word_t load_data;

    assign ofs = addr[1:0];

    // Replicate store data so every lane sees it
    always_comb begin
        case (mem_size)
            rv_pkg::SIZE_B: begin
                mem_wdata = {4{rs2_data[7:0]}};
                strobe    = 4'b0001 << ofs;
            end
            rv_pkg::SIZE_H: begin
                mem_wdata = {2{rs2_data[15:0]}};
                strobe    = ofs[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_wdata = rs2_data;
                strobe    = 4'b1111;
            end
        endcase
    end

    assign mem_we = (mem_wr && rst_n) ? strobe : 4'b0000;

    // Half access ignores address bit 0
    assign ld_byte = mem_rdata[{ofs, 3'b000} +: 8];
    assign ld_half = ofs[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (mem_size)
            rv_pkg::SIZE_B: begin
                load_data = {{(rv_pkg::XLEN-8){ld_byte[7] & ~load_unsigned}}, ld_byte};
            end
            rv_pkg::SIZE_H: begin
                load_data = {{(rv_pkg::XLEN-16){ld_half[15] & ~load_unsigned}}, ld_half};
            end
            default: load_data = mem_rdata;
        endcase
        if (!mem_rd) begin
            load_data = '0;
        end
    end

    always_comb begin
        case (wb_sel)
            rv_pkg::WB_MEM: rd_data = load_data;
            rv_pkg::WB_PC4: rd_data = pc_plus4;
            default:        rd_data = alu_result;
        endcase
    end

    always_comb begin
        assert (mem_wr || mem_we == 4'b0000)
            else $error("lsu: byte strobes raised without a store");
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_data,
    input  logic              reg_wen,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    a_x0_reads_zero: assert property (@(posedge clk)
        (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0))
        else $error("reg_file: x0 read returned nonzero");

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_rdata,
    output rv_pkg::word_t dmem_addr,
    input  rv_pkg::word_t dmem_rdata,
    output rv_pkg::word_t dmem_wdata,
    output logic [3:0]    dmem_we
);

    rv_pkg::word_t     pc;
    rv_pkg::word_t     pc_plus4;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     rd_data;
    logic              a_sel;
    logic              b_sel;
    rv_pkg::alu_sel_t  alu_sel;
    rv_pkg::imm_sel_t  imm_sel;
    logic              br_un;
    logic              br_eq;
    logic              br_lt;
    logic              pc_sel;
    logic              reg_wen;
    logic              mem_wr;
    logic              mem_rd;
    rv_pkg::mem_size_t mem_size;
    logic              load_unsigned;
    rv_pkg::wb_sel_t   wb_sel;

    assign imem_addr = pc;
    assign dmem_addr = alu_result;

    fetch_unit u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_sel   (pc_sel),
        .target   (alu_result),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    instr_ctl u_ctl (
        .instruction   (imem_rdata),
        .br_eq         (br_eq),
        .br_lt         (br_lt),
        .a_sel         (a_sel),
        .b_sel         (b_sel),
        .alu_sel       (alu_sel),
        .imm_sel       (imm_sel),
        .br_un         (br_un),
        .pc_sel        (pc_sel),
        .reg_wen       (reg_wen),
        .mem_wr        (mem_wr),
        .mem_rd        (mem_rd),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .wb_sel        (wb_sel)
    );

    imm_gen u_imm (
        .instruction (imem_rdata),
        .imm_sel     (imm_sel),
        .imm         (imm)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (imem_rdata[19:15]),
        .rs2_addr (imem_rdata[24:20]),
        .rd_addr  (imem_rdata[11:7]),
        .rd_data  (rd_data),
        .reg_wen  (reg_wen),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .alu_sel    (alu_sel),
        .br_un      (br_un),
        .alu_result (alu_result),
        .br_eq      (br_eq),
        .br_lt      (br_lt)
    );

    lsu u_lsu (
        .rst_n         (rst_n),
        .addr          (alu_result),
        .rs2_data      (rs2_data),
        .alu_result    (alu_result),
        .pc_plus4      (pc_plus4),
        .mem_rdata     (dmem_rdata),
        .mem_wr        (mem_wr),
        .mem_rd        (mem_rd),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .wb_sel        (wb_sel),
        .mem_wdata     (dmem_wdata),
        .mem_we        (dmem_we),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Branch compares
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // ALU operations for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } alu_sel_t;

    typedef enum logic [1:0] {
        WB_MEM,
        WB_ALU,
        WB_PC4
    } wb_sel_t;

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_t;

endpackage

`default_nettype wire

// File: tb_ref_model.sv
`default_nettype none

module tb_ref_model (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t pc,
    output logic [3:0]    st_we,
    output rv_pkg::word_t st_addr,
    output rv_pkg::word_t st_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // Private copies of both memories, loaded by the testbench top
    rv_pkg::word_t imem [0:255];
    rv_pkg::word_t dmem [0:255];
    rv_pkg::word_t regs [0:31];

    function automatic rv_pkg::word_t alu(input logic [2:0] f3, input logic alt,
                                          input rv_pkg::word_t a, input rv_pkg::word_t b);
        rv_pkg::word_t r;
        case (f3)
            rv_pkg::F3_ADD:  r = alt ? a - b : a + b;
            rv_pkg::F3_SLL:  r = a << b[4:0];
            rv_pkg::F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::F3_SLTU: r = {31'b0, a < b};
            rv_pkg::F3_XOR:  r = a ^ b;
            rv_pkg::F3_SR: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            rv_pkg::F3_OR:   r = a | b;
            default:         r = a & b;
        endcase
        return r;
    endfunction

    // Effects of the instruction at the current PC, no state changes
    task automatic decode(output rv_pkg::word_t next_pc, output logic wr,
                          output rv_pkg::word_t res, output logic [3:0] we,
                          output rv_pkg::word_t addr, output rv_pkg::word_t data);
        rv_pkg::word_t ins;
        rv_pkg::word_t rs1;
        rv_pkg::word_t rs2;
        rv_pkg::word_t imm_i;
        rv_pkg::word_t imm_s;
        rv_pkg::word_t ea;
        rv_pkg::word_t lw;
        rv_pkg::word_t sh;
        logic [2:0]    f3;
        logic          take;
        ins     = imem[pc[9:2]];
        f3      = ins[14:12];
        rs1     = regs[ins[19:15]];
        rs2     = regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        next_pc = pc + 32'd4;
        wr      = 1'b0;
        res     = '0;
        we      = 4'b0000;
        addr    = '0;
        data    = '0;
        take    = 1'b0;
        case (ins[6:0])
            rv_pkg::OPC_LUI: begin
                wr  = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            rv_pkg::OPC_AUIPC: begin
                wr  = 1'b1;
                res = pc + {ins[31:12], 12'b0};
            end
            rv_pkg::OPC_JAL: begin
                wr      = 1'b1;
                res     = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_pkg::OPC_JALR: begin
                wr      = 1'b1;
                res     = pc + 32'd4;
                next_pc = rs1 + imm_i;
            end
            rv_pkg::OPC_BRANCH: begin
                case (f3)
                    rv_pkg::F3_BEQ:  take = (rs1 == rs2);
                    rv_pkg::F3_BNE:  take = (rs1 != rs2);
                    rv_pkg::F3_BLT:  take = ($signed(rs1) < $signed(rs2));
                    rv_pkg::F3_BGE:  take = ($signed(rs1) >= $signed(rs2));
                    rv_pkg::F3_BLTU: take = (rs1 < rs2);
                    rv_pkg::F3_BGEU: take = (rs1 >= rs2);
                    default:         take = 1'b0;
                endcase
                if (take) begin
                    next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            rv_pkg::OPC_LOAD: begin
                ea = rs1 + imm_i;
                lw = dmem[ea[9:2]];
                sh = lw >> {ea[1:0], 3'b000};
                wr = 1'b1;
                case (f3)
                    rv_pkg::F3_LB:  res = {{24{sh[7]}}, sh[7:0]};
                    rv_pkg::F3_LBU: res = {24'b0, sh[7:0]};
                    rv_pkg::F3_LH:  res = ea[1] ? {{16{lw[31]}}, lw[31:16]}
                                                : {{16{lw[15]}}, lw[15:0]};
                    rv_pkg::F3_LHU: res = ea[1] ? {16'b0, lw[31:16]} : {16'b0, lw[15:0]};
                    rv_pkg::F3_LW:  res = lw;
                    default:        wr = 1'b0;
                endcase
            end
            rv_pkg::OPC_STORE: begin
                ea   = rs1 + imm_s;
                addr = {ea[31:2], 2'b00};
                case (f3)
                    rv_pkg::F3_SB: begin
                        we   = 4'b0001 << ea[1:0];
                        data = {24'b0, rs2[7:0]} << {ea[1:0], 3'b000};
                    end
                    rv_pkg::F3_SH: begin
                        we   = ea[1] ? 4'b1100 : 4'b0011;
                        data = ea[1] ? {rs2[15:0], 16'b0} : {16'b0, rs2[15:0]};
                    end
                    rv_pkg::F3_SW: begin
                        we   = 4'b1111;
                        data = rs2;
                    end
                    default: we = 4'b0000;
                endcase
            end
            rv_pkg::OPC_OPIMM: begin
                wr  = 1'b1;
                res = alu(f3, f3 == rv_pkg::F3_SR && ins[30], rs1, imm_i);
            end
            rv_pkg::OPC_OP: begin
                wr  = 1'b1;
                res = alu(f3, ins[30] && (f3 == rv_pkg::F3_ADD || f3 == rv_pkg::F3_SR),
                          rs1, rs2);
            end
            default: wr = 1'b0;
        endcase
        next_pc[1:0] = 2'b00;
    endtask

    always @(posedge clk) begin
        rv_pkg::word_t nxt;
        rv_pkg::word_t res;
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
        logic [4:0]    rd;
        logic [3:0]    we;
        logic          wr;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            pc = rv_pkg::RESET_PC;
        end else begin
            rd = imem[pc[9:2]][11:7];
            decode(nxt, wr, res, we, addr, data);
            if (wr && rd != 5'd0) begin
                regs[rd] = res;
            end
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    dmem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
            pc = nxt;
        end
        // Expected store of the instruction now at the PC
        decode(nxt, wr, res, st_we, st_addr, st_data);
    end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR    = 2000;
    localparam int RESET_CYCLES = 10;
    // Reset plus all instructions fit well inside this
    localparam int MAX_CYCLES   = 3000;

    logic          clk = 1'b0;
    logic          rst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_rdata;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_rdata;
    rv_pkg::word_t dmem_wdata;
    logic [3:0]    dmem_we;
    rv_pkg::word_t exp_pc;
    rv_pkg::word_t exp_addr;
    rv_pkg::word_t exp_data;
    logic [3:0]    exp_we;
    rv_pkg::word_t imem [0:255];
    rv_pkg::word_t dmem [0:255];
    integer        seed;
    int            cycles = 0;

    rv_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we)
    );

    tb_ref_model model0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (exp_pc),
        .st_we   (exp_we),
        .st_addr (exp_addr),
        .st_data (exp_data)
    );

    // Both memories wrap on the word index
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_we[b]) begin
                dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            report_failure();
        end
    end

    task automatic compare_word(input string name, input rv_pkg::word_t got,
                                input rv_pkg::word_t exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic is_known(input logic [6:0] op);
        return op == rv_pkg::OPC_LUI || op == rv_pkg::OPC_AUIPC || op == rv_pkg::OPC_JAL ||
               op == rv_pkg::OPC_JALR || op == rv_pkg::OPC_BRANCH || op == rv_pkg::OPC_LOAD ||
               op == rv_pkg::OPC_STORE || op == rv_pkg::OPC_OPIMM || op == rv_pkg::OPC_OP;
    endfunction

    function automatic rv_pkg::word_t random_instr();
        rv_pkg::word_t w;
        logic [6:0]    op;
        logic [2:0]    f3;
        int            cls;
        int            m;
        w   = $random(seed);
        f3  = w[14:12];
        cls = $unsigned($random(seed)) % 20;
        case (cls)
            0: begin
                op = w[6:0];
                while (is_known(op)) begin
                    op = op + 7'd1;
                end
            end
            1: op = rv_pkg::OPC_LUI;
            2: op = rv_pkg::OPC_AUIPC;
            3: op = rv_pkg::OPC_JAL;
            4: begin
                op = rv_pkg::OPC_JALR;
                f3 = 3'b000;
            end
            5, 6, 7: begin
                op = rv_pkg::OPC_BRANCH;
                // 010 and 011 are not branches
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
            end
            8, 9, 10: begin
                op = rv_pkg::OPC_LOAD;
                m  = int'(f3) % 5;
                f3 = (m > 2) ? 3'(m + 1) : 3'(m);
            end
            11, 12, 13: begin
                op = rv_pkg::OPC_STORE;
                f3 = 3'(int'(f3) % 3);
            end
            14, 15, 16: begin
                op = rv_pkg::OPC_OPIMM;
                if (f3 == rv_pkg::F3_SLL || f3 == rv_pkg::F3_SR) begin
                    w[31:25] = {1'b0, w[30] && f3 == rv_pkg::F3_SR, 5'b0};
                end
            end
            default: begin
                op = rv_pkg::OPC_OP;
                w[31:25] = {1'b0, w[30] && (f3 == rv_pkg::F3_ADD || f3 == rv_pkg::F3_SR), 5'b0};
            end
        endcase
        w[14:12] = f3;
        w[6:0]   = op;
        return w;
    endfunction

    task automatic load_program();
        rv_pkg::word_t w;
        int            k;
        k = 0;
        // LUI then ADDI gives every register a random start value
        for (int r = 1; r < 32; r++) begin
            w         = $random(seed);
            imem[k]   = {w[31:12], 5'(r), rv_pkg::OPC_LUI};
            imem[k+1] = {w[11:0], 5'(r), rv_pkg::F3_ADD, 5'(r), rv_pkg::OPC_OPIMM};
            k += 2;
        end
        for (int i = k; i < 256; i++) begin
            imem[i] = random_instr();
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i]         = $random(seed);
            model0.imem[i]  = imem[i];
            model0.dmem[i]  = dmem[i];
        end
    endtask

    task automatic check_cycle();
        rv_pkg::word_t mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{exp_we[b]}};
        end
        compare_word("imem_addr", imem_addr, exp_pc);
        compare_word("dmem_we", {28'b0, dmem_we}, {28'b0, exp_we});
        if (exp_we != 4'b0000) begin
            compare_word("dmem_addr", {dmem_addr[31:2], 2'b00}, exp_addr);
            compare_word("dmem_wdata", dmem_wdata & mask, exp_data & mask);
        end
    endtask

    initial begin
        seed  = 67125;
        rst_n = 1'b0;
        load_program();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_word("imem_addr", imem_addr, rv_pkg::RESET_PC);
            compare_word("dmem_we", {28'b0, dmem_we}, 32'h0);
        end
        rst_n = 1'b1;
        // First cycle out of reset still fetches from the reset vector
        #1;
        compare_word("imem_addr", imem_addr, rv_pkg::RESET_PC);
        check_cycle();
        // One instruction retires per rising edge
        for (int n = 1; n <= NUM_INSTR; n++) begin
            @(negedge clk);
            check_cycle();
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
